// ==== design/noc_defs.svh ====
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// flit geometry. The id sits in the top bits and the payload fills the rest.
`define FLIT_WIDTH 32
`define FLIT_ID_WIDTH 3

// the header length field is the low part of the payload.
`define LEN_WIDTH 12

// router geometry.
`define NUM_PORTS 5
`define PORT_WIDTH 3

// entries per input FIFO.
`define FIFO_DEPTH 4

// flit id codes.
`define FLIT_HEADER 3'd1
`define FLIT_BODY 3'd2
`define FLIT_TAIL 3'd3

`endif

// ==== design/nocPkg.sv ====
`include "noc_defs.svh"

package nocPkg;

  typedef logic [`FLIT_WIDTH-1:0] flit_t;
  typedef logic [`FLIT_ID_WIDTH-1:0] flitId_t;
  typedef logic [`LEN_WIDTH-1:0] slotLen_t;
  typedef logic [`PORT_WIDTH-1:0] portIdx_t;

  // one bit per port, indexed by portIdx_t.
  typedef logic [`NUM_PORTS-1:0] portMask_t;

  // one-hot grant states, idle in the lowest bit.
  typedef enum logic [5:0] {
    arbIdle = 6'b000001,
    grantL  = 6'b000010,
    grantN  = 6'b000100,
    grantE  = 6'b001000,
    grantW  = 6'b010000,
    grantS  = 6'b100000
  } arbState_t;

  localparam portIdx_t portL = 3'd0;
  localparam portIdx_t portN = 3'd1;
  localparam portIdx_t portE = 3'd2;
  localparam portIdx_t portW = 3'd3;
  localparam portIdx_t portS = 3'd4;

  function automatic flitId_t flitIdOf(flit_t flit);
    return flit[`FLIT_WIDTH-1 -: `FLIT_ID_WIDTH];
  endfunction

  function automatic slotLen_t flitLenOf(flit_t flit);
    return flit[`LEN_WIDTH-1:0];
  endfunction

  function automatic logic isHeader(flit_t flit);
    return flitIdOf(flit) == `FLIT_HEADER;
  endfunction

endpackage

// ==== design/inputPort.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module inputPort #(
  parameter int depth = `FIFO_DEPTH
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           push,
  input  nocPkg::flit_t  pushFlit,
  input  logic           pop,
  output logic           req,
  output nocPkg::flit_t  headFlit,
  output logic           full
);

  import nocPkg::*;

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW = $clog2(depth + 1);

  typedef logic [ptrW-1:0] ptr_t;
  typedef logic [cntW-1:0] cnt_t;

  flit_t mem [depth];
  ptr_t  rdPtr;
  ptr_t  wrPtr;
  cnt_t  count;
  logic  doPush;
  logic  doPop;

  // pointers wrap by compare so that any depth works, not only powers of two.
  function automatic ptr_t nextPtr(ptr_t ptr);
    if (ptr == ptr_t'(depth - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == cnt_t'(depth));
  assign req = (count != '0);
  assign headFlit = mem[rdPtr];

  // a push into a full FIFO is lost, even when a pop frees a slot on the same edge.
  assign doPush = push && !full;
  assign doPop = pop && req;

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      mem[wrPtr] <= pushFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
      begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop)
      begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({doPush, doPop})
        2'b10:
          count <= count + 1'b1;
        2'b01:
          count <= count - 1'b1;
        default:
          count <= count;
      endcase
    end
  end

endmodule

// ==== design/packetTimer.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module packetTimer (
  input  logic           clk,
  input  logic           rst,
  input  nocPkg::flit_t  headFlit,
  input  logic           run,
  output logic           timesUp
);

  import nocPkg::*;

  slotLen_t slotLen;
  slotLen_t count;

  // the slot length follows every header that reaches the head of the FIFO,
  // so it is ready by the time the port wins the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slotLen <= '0;
    end
    else if (isHeader(headFlit))
    begin
      slotLen <= flitLenOf(headFlit);
    end
  end

  // one count per popped flit; the count restarts whenever the tenure pauses.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;
    end
  end

  assign timesUp = (count == slotLen);

endmodule

// ==== design/outputArbiter.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module outputArbiter (
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::portMask_t req,
  input  nocPkg::flit_t     headFlits [`NUM_PORTS],
  output nocPkg::portMask_t pop,
  output logic              outValid,
  output nocPkg::flit_t     outFlit,
  output nocPkg::portIdx_t  outPort
);

  import nocPkg::*;

  arbState_t state;
  arbState_t nextState;
  portMask_t run;
  portMask_t timesUp;
  portIdx_t  grantPort;
  logic      granted;

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : g_timer
    packetTimer i_packetTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[p]),
      .run      (run[p]),
      .timesUp  (timesUp[p])
    );
  end

  function automatic arbState_t portState(portIdx_t port);
    return arbState_t'(6'b000010 << port);
  endfunction

  function automatic portIdx_t nextPort(portIdx_t port);
    if (port == portIdx_t'(`NUM_PORTS - 1))
    begin
      return portL;
    end
    return port + 1'b1;
  endfunction

  // first requesting port in circular order, starting at first and looking at
  // no more than tries ports. Nothing found means idle.
  function automatic arbState_t pickNext(portMask_t reqs, portIdx_t first, int tries);
    arbState_t pick;
    int        idx;
    logic      found;
    pick = arbIdle;
    found = 1'b0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      idx = int'(first) + i;
      if (idx >= `NUM_PORTS)
      begin
        idx = idx - `NUM_PORTS;
      end
      if ((i < tries) && !found && reqs[idx])
      begin
        pick = portState(portIdx_t'(idx));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // an encoding outside the enum falls into the idle branch and recovers.
  always_comb
  begin
    granted = 1'b1;
    grantPort = portL;
    case (state)
      grantL:
        grantPort = portL;
      grantN:
        grantPort = portN;
      grantE:
        grantPort = portE;
      grantW:
        grantPort = portW;
      grantS:
        grantPort = portS;
      default:
        granted = 1'b0;
    endcase
  end

  // from idle the search starts at L and covers every port. From a grant it
  // starts after the current port and never comes back to it.
  always_comb
  begin
    run = '0;
    if (!granted)
    begin
      nextState = pickNext(req, portL, `NUM_PORTS);
    end
    else if (req[grantPort] && !timesUp[grantPort])
    begin
      run[grantPort] = 1'b1;
      nextState = state;
    end
    else
    begin
      nextState = pickNext(req, nextPort(grantPort), `NUM_PORTS - 1);
    end
  end

  // the timer advances once per pop, so run doubles as the pop strobe.
  assign pop = run;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outFlit <= headFlits[grantPort];
      outPort <= grantPort;
    end
  end

endmodule

// ==== design/routerOutput.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module routerOutput (
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::portMask_t inValid,
  input  nocPkg::flit_t     inFlit [`NUM_PORTS],
  output nocPkg::portMask_t inFull,
  output logic              outValid,
  output nocPkg::flit_t     outFlit,
  output nocPkg::portIdx_t  outPort
);

  import nocPkg::*;

  portMask_t req;
  portMask_t pop;
  flit_t     headFlits [`NUM_PORTS];

  // port order L, N, E, W, S, which is also the arbiter's idle priority.
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : g_port
    inputPort #(
      .depth (`FIFO_DEPTH)
    ) i_inputPort (
      .clk      (clk),
      .rst      (rst),
      .push     (inValid[p]),
      .pushFlit (inFlit[p]),
      .pop      (pop[p]),
      .req      (req[p]),
      .headFlit (headFlits[p]),
      .full     (inFull[p])
    );
  end

  outputArbiter i_outputArbiter (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .headFlits (headFlits),
    .pop       (pop),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outPort   (outPort)
  );

endmodule

// ==== bench/routerOutput_assertions.sv ====
`timescale 1ns/1ps

module routerOutput_assertions (
  input logic              clk,
  input logic              rst,
  input nocPkg::portMask_t req,
  input nocPkg::portMask_t pop,
  input logic              outValid
);

  int failures = 0;

  // the output channel serves a single port per cycle.
  onePop : assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
  else
  begin
    failures++;
    $error("more than one pop in one cycle, pop = %b", pop);
  end

  popNeedsReq : assert property (@(posedge clk) disable iff (rst) ((pop & ~req) == '0))
  else
  begin
    failures++;
    $error("pop without a request, pop = %b, req = %b", pop, req);
  end

  idleAfterReset : assert property (@(posedge clk) rst |=> !outValid)
  else
  begin
    failures++;
    $error("outValid is high in the cycle after reset");
  end

endmodule

bind outputArbiter routerOutput_assertions i_arbiterAssertions (
  .clk      (clk),
  .rst      (rst),
  .req      (req),
  .pop      (pop),
  .outValid (outValid)
);

// ==== bench/routerOutput_tb.sv ====
`timescale 1ns/1ps
`include "noc_defs.svh"

module routerOutput_tb;

  import nocPkg::*;

  localparam int maxWait = 200;

  logic      clk;
  logic      rst;
  portMask_t inValid;
  flit_t     inFlit [`NUM_PORTS];
  portMask_t inFull;
  logic      outValid;
  flit_t     outFlit;
  portIdx_t  outPort;

  // flits still to push, flits still to come out, and the port order of delivery.
  flit_t    stim [`NUM_PORTS][$];
  flit_t    expFlits [`NUM_PORTS][$];
  portIdx_t expPorts [$];

  routerOutput i_routerOutput (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inFull   (inFull),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compareFlit(input string testName, input flit_t expected, input flit_t actual);
    if (actual !== expected)
      abortRun($sformatf("[ERROR] %s: expected flit %h, actual %h", testName, expected, actual));
  endtask

  task automatic comparePort(input string testName, input portIdx_t expected,
                             input portIdx_t actual);
    if (actual !== expected)
      abortRun($sformatf("[ERROR] %s: expected port %0d, actual %0d", testName, expected, actual));
  endtask

  task automatic compareMask(input string testName, input portMask_t expected,
                             input portMask_t actual);
    if (actual !== expected)
      abortRun($sformatf("[ERROR] %s: expected mask %b, actual %b", testName, expected, actual));
  endtask

  task automatic compareBit(input string testName, input logic expected, input logic actual);
    if (actual !== expected)
      abortRun($sformatf("[ERROR] %s: expected bit %b, actual %b", testName, expected, actual));
  endtask

  // random payload; a header keeps the slot length in its low bits.
  function automatic flit_t makeFlit(input flitId_t id, input slotLen_t len);
    flit_t flit;
    flit = $urandom();
    flit[`FLIT_WIDTH-1 -: `FLIT_ID_WIDTH] = id;
    if (id == `FLIT_HEADER)
      flit[`LEN_WIDTH-1:0] = len;
    return flit;
  endfunction

  task automatic addPacket(input portIdx_t port, input slotLen_t len, input int bodies);
    flit_t flit;
    for (int i = 0; i <= bodies; i++)
    begin
      if (i == 0)
        flit = makeFlit(`FLIT_HEADER, len);
      else
        flit = makeFlit(`FLIT_BODY, '0);
      stim[port].push_back(flit);
      expFlits[port].push_back(flit);
    end
  endtask

  // one flit per port and cycle until every stimulus queue is empty.
  task automatic driveStimulus();
    logic pending;
    pending = 1'b1;
    while (pending)
    begin
      @(posedge clk);
      pending = 1'b0;
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        if (stim[p].size() > 0)
        begin
          inValid[p] <= 1'b1;
          inFlit[p] <= stim[p].pop_front();
          pending = 1'b1;
        end
        else
        begin
          inValid[p] <= 1'b0;
        end
      end
    end
  endtask

  task automatic waitForOutput(input string testName);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!outValid && cycles < maxWait)
    begin
      cycles++;
      @(negedge clk);
    end
    if (!outValid)
      abortRun($sformatf("%s: no flit came out within %0d cycles", testName, maxWait));
  endtask

  task automatic collectFlits(input string testName);
    portIdx_t port;
    while (expPorts.size() > 0)
    begin
      waitForOutput(testName);
      port = expPorts.pop_front();
      comparePort(testName, port, outPort);
      compareFlit(testName, expFlits[port].pop_front(), outFlit);
    end
  endtask

  task automatic expectQuiet(input string testName, input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      compareBit(testName, 1'b0, outValid);
      compareMask(testName, '0, inFull);
    end
  endtask

  // the port is never served while this runs, so full follows the push count.
  task automatic watchFill(input string testName, input portIdx_t port, input int cycles);
    int pushes;
    pushes = 0;
    repeat (cycles)
    begin
      @(negedge clk);
      compareBit(testName, pushes >= `FIFO_DEPTH, inFull[port]);
      if (inValid[port])
        pushes++;
    end
  endtask

  task automatic testSinglePacket();
    addPacket(portE, 12'd8, 3);
    repeat (4)
      expPorts.push_back(portE);
    fork
      driveStimulus();
      collectFlits("singlePacket");
    join
    expectQuiet("singlePacket", 10);
  endtask

  task automatic testIdlePriority();
    addPacket(portS, 12'd1, 0);
    addPacket(portN, 12'd1, 0);
    expPorts.push_back(portN);
    expPorts.push_back(portS);
    fork
      driveStimulus();
      collectFlits("idlePriority");
    join
    expectQuiet("idlePriority", 10);
  endtask

  // each tenure carries one two-flit packet, so the ports alternate in pairs.
  task automatic testRotation();
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      addPacket(portIdx_t'(p), 12'd2, 1);
      addPacket(portIdx_t'(p), 12'd2, 1);
    end
    for (int r = 0; r < 2; r++)
    begin
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        expPorts.push_back(portIdx_t'(p));
        expPorts.push_back(portIdx_t'(p));
      end
    end
    fork
      driveStimulus();
      collectFlits("rotation");
    join
    expectQuiet("rotation", 10);
  endtask

  task automatic testFullDrop();
    addPacket(portL, 12'd40, 39);
    addPacket(portN, 12'd4, 3);
    // the last two N flits meet a full FIFO and are lost.
    stim[portN].push_back(makeFlit(`FLIT_BODY, '0));
    stim[portN].push_back(makeFlit(`FLIT_BODY, '0));
    repeat (40)
      expPorts.push_back(portL);
    repeat (4)
      expPorts.push_back(portN);
    fork
      driveStimulus();
      collectFlits("fullDrop");
      watchFill("fullDrop", portN, 12);
    join
    expectQuiet("fullDrop", 10);
  endtask

  initial
  begin
    void'($urandom(26));
    rst <= 1'b1;
    inValid <= '0;
    for (int p = 0; p < `NUM_PORTS; p++)
      inFlit[p] <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    expectQuiet("reset", 10);
    testSinglePacket();
    testIdlePriority();
    testRotation();
    testFullDrop();
    if (i_routerOutput.i_outputArbiter.i_arbiterAssertions.failures != 0)
    begin
      $display("the arbiter assertions failed during the run");
      $display("=== FAIL ===");
      $fatal(1, "assertion failures on the arbiter");
    end
    else
    begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
+incdir+design
design/nocPkg.sv
design/inputPort.sv
design/packetTimer.sv
design/outputArbiter.sv
design/routerOutput.sv
bench/routerOutput_assertions.sv
bench/routerOutput_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module routerOutput_tb -f sources.f \
  && ./obj_dir/VrouterOutput_tb > sim.log 2>&1 \
  || echo "build or simulation stopped early"

cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
